//--- all.f
hdl/loader_pkg.sv
hdl/uart_receiver.sv
hdl/srec_parser.sv
hdl/write_fifo.sv
hdl/ahb_write_bridge.sv
hdl/ahb_ram.sv
hdl/srec_loader_top.sv
tests/clock_gen.sv
tests/srec_loader_asserts.sv
tests/srec_loader_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = srec_loader_tb
FILE_LIST  = all.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/srec_loader_tb.sv
module srec_loader_tb;
    import loader_pkg::*;

    localparam int CLKS_PER_BIT  = 8;
    localparam int RAM_WORDS     = 256;
    localparam int RAM_BYTES     = RAM_WORDS * 4;
    localparam int RECS_PER_LOAD = 6;
    localparam int FMT_RECS      = 3;
    localparam int EXT_OPS       = 200;
    // S, type, CR and LF plus count, a 4-byte address, 16 data bytes and checksum
    localparam int MAX_REC_CHARS = 4 + 2 * (1 + 4 + 16 + 1);
    localparam int NUM_RECORDS   = 2 * (RECS_PER_LOAD + 2) + 3 + 1 + (FMT_RECS + 2);
    localparam int MARGIN        = 100000;
    localparam int TIMEOUT       = NUM_RECORDS * MAX_REC_CHARS * 10 * CLKS_PER_BIT * 8 + MARGIN;

    logic     clk;
    logic     rst_n;
    logic     big_endian;
    logic     uart_rx;
    ahb_req_t ext_req;
    word_t    hrdata;
    logic     hready;
    logic     hresp;
    logic     cpu_reset;
    logic     format_error;
    logic     checksum_error;

    int       seed;
    int       errors;
    int       checks;
    byte_t    rec_data [16];
    // reference RAM, indexed by word and physical byte lane
    byte_t    phys [RAM_BYTES];

    clock_gen #(
        .PERIOD ( 8 )
    ) clock_gen_inst (
        .clk ( clk )
    );

    srec_loader_top #(
        .CLKS_PER_BIT ( CLKS_PER_BIT ),
        .FIFO_DEPTH   ( 4            ),
        .RAM_WORDS    ( RAM_WORDS    )
    ) srec_loader_top_inst (
        .HCLK           ( clk            ),
        .rst_n          ( rst_n          ),
        .big_endian     ( big_endian     ),
        .uart_rx        ( uart_rx        ),
        .ext_req        ( ext_req        ),
        .hrdata         ( hrdata         ),
        .hready         ( hready         ),
        .hresp          ( hresp          ),
        .cpu_reset      ( cpu_reset      ),
        .format_error   ( format_error   ),
        .checksum_error ( checksum_error )
    );

    // byte address to physical lane, big endian puts address 0 in the top lane
    function automatic logic [1:0] lane_of(input addr_t a);
        return big_endian ? 2'd3 - a[1:0] : a[1:0];
    endfunction

    function automatic int phys_index(input addr_t a);
        return (int'(a % RAM_BYTES) & ~3) + int'(lane_of(a));
    endfunction

    function automatic word_t model_word(input int w);
        return {phys[4 * w + 3], phys[4 * w + 2], phys[4 * w + 1], phys[4 * w]};
    endfunction

    // each covered byte takes the bus data from its own lane
    task automatic apply_write(input addr_t addr, input int nbytes, input word_t wdata);
        addr_t b;
        for (int k = 0; k < nbytes; k++) begin
            b = addr + addr_t'(k);
            phys[phys_index(b)] = wdata[8 * lane_of(b) +: 8];
        end
    endtask

    function automatic byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    function automatic int addr_len(input byte_t rtype);
        case (rtype)
            "0", "1", "9": return 2;
            "2", "8":      return 3;
            default:       return 4;
        endcase
    endfunction

    // 8N1 frame, lsb first
    task automatic send_char(input byte_t c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
    endtask

    task automatic send_hex(input byte_t b);
        send_char(hex_char(b[7:4]));
        send_char(hex_char(b[3:0]));
    endtask

    task automatic send_record(input byte_t rtype, input addr_t addr, input int n,
                               input logic bad_sum);
        int    alen;
        byte_t count;
        byte_t sum;
        alen  = addr_len(rtype);
        count = byte_t'(alen + n + 1);
        sum   = count;
        send_char("S");
        send_char(rtype);
        send_hex(count);
        for (int i = alen - 1; i >= 0; i--) begin
            send_hex(addr[8 * i +: 8]);
            sum += addr[8 * i +: 8];
        end
        for (int i = 0; i < n; i++) begin
            send_hex(rec_data[i]);
            sum += rec_data[i];
        end
        send_hex(bad_sum ? (~sum ^ 8'h5a) : ~sum);
        send_char(8'h0d);
        send_char(8'h0a);
    endtask

    // the bytes land in RAM even when the checksum turns out bad
    task automatic send_data_record(input logic bad_sum);
        byte_t rtype;
        int    n;
        addr_t addr;
        rtype = byte_t'("1" + ($unsigned($random(seed)) % 3));
        n     = 1 + int'($unsigned($random(seed)) % 16);
        addr  = addr_t'($unsigned($random(seed)) % (RAM_BYTES - n + 1));
        for (int k = 0; k < n; k++) begin
            rec_data[k] = byte_t'($random(seed));
            apply_write(addr + addr_t'(k), 1, {4{rec_data[k]}});
        end
        send_record(rtype, addr, n, bad_sum);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (cpu_reset && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        checks++;
        if (cpu_reset) begin
            errors++;
            $display("cpu_reset did not fall after the terminator record");
        end
        checks++;
        if (format_error || checksum_error) begin
            errors++;
            $display("** Error: {format_error, checksum_error} = %h, expected %h",
                     {format_error, checksum_error}, 2'b00);
        end
    endtask

    task automatic run_load(input int nrecs);
        rec_data[0] = "H";
        rec_data[1] = "D";
        rec_data[2] = "R";
        send_record("0", '0, 3, 1'b0);
        checks++;
        if (cpu_reset !== 1'b1) begin
            errors++;
            $display("** Error: cpu_reset = %h, expected %h", cpu_reset, 1'b1);
        end
        for (int r = 0; r < nrecs; r++) begin
            send_data_record(1'b0);
        end
        send_record("9", '0, 0, 1'b0);
        wait_idle();
    endtask

    // zero wait states and an OKAY response are expected in every data phase
    task automatic ahb_access(input logic write, input hsize_t size, input addr_t addr,
                              input word_t wdata, output word_t rdata);
        @(posedge clk);
        #1;
        ext_req.haddr  = addr;
        ext_req.htrans = HTRANS_NONSEQ;
        ext_req.hsize  = size;
        ext_req.hwrite = write;
        @(posedge clk);
        #1;
        ext_req.htrans = HTRANS_IDLE;
        ext_req.hwdata = wdata;
        rdata          = hrdata;
        checks++;
        if (hready !== 1'b1 || hresp !== 1'b0) begin
            errors++;
            $display("** Error: {hready, hresp} = %h, expected %h", {hready, hresp}, 2'b10);
        end
    endtask

    task automatic verify_ram();
        word_t rdata;
        word_t expected;
        for (int w = 0; w < RAM_WORDS; w++) begin
            ahb_access(1'b0, HSIZE_WORD, addr_t'(4 * w), '0, rdata);
            expected = model_word(w);
            checks++;
            if (rdata !== expected) begin
                errors++;
                $display("** Error: hrdata at %h = %h, expected %h", 4 * w, rdata, expected);
            end
        end
    endtask

    task automatic ext_random(input int nops);
        hsize_t size;
        int     nbytes;
        addr_t  addr;
        logic   write;
        word_t  wdata;
        word_t  rdata;
        word_t  expected;
        for (int i = 0; i < nops; i++) begin
            size   = hsize_t'($unsigned($random(seed)) % 3);
            nbytes = 1 << int'(size);
            addr   = addr_t'($unsigned($random(seed)) % RAM_BYTES) & ~addr_t'(nbytes - 1);
            write  = ($random(seed) % 2) != 0;
            wdata  = word_t'($random(seed));
            ahb_access(write, size, addr, wdata, rdata);
            if (write) begin
                apply_write(addr, nbytes, wdata);
            end else begin
                expected = model_word(int'(addr >> 2));
                checks++;
                if (rdata !== expected) begin
                    errors++;
                    $display("** Error: hrdata at %h = %h, expected %h", addr, rdata, expected);
                end
            end
        end
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        word_t fill;
        word_t rdata;
        seed       = 32'h50af;
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        big_endian = 1'b0;
        uart_rx    = 1'b1;
        ext_req    = '{haddr: '0, htrans: HTRANS_IDLE, hsize: HSIZE_WORD,
                       hwrite: 1'b0, hwdata: '0};
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        checks++;
        if ({cpu_reset, format_error, checksum_error} !== 3'b000) begin
            errors++;
            $display("** Error: {cpu_reset, format_error, checksum_error} = %h, expected %h",
                     {cpu_reset, format_error, checksum_error}, 3'b000);
        end

        for (int w = 0; w < RAM_WORDS; w++) begin
            fill = word_t'(32'h9e37_79b9 * (w + 1)) ^ word_t'(w << 20);
            ahb_access(1'b1, HSIZE_WORD, addr_t'(4 * w), fill, rdata);
            apply_write(addr_t'(4 * w), 4, fill);
        end
        verify_ram();

        run_load(RECS_PER_LOAD);
        verify_ram();
        ext_random(EXT_OPS);
        verify_ram();

        big_endian = 1'b1;
        run_load(RECS_PER_LOAD);
        verify_ram();

        send_data_record(1'b1);
        checks++;
        if (checksum_error !== 1'b1) begin
            errors++;
            $display("** Error: checksum_error = %h, expected %h", checksum_error, 1'b1);
        end
        send_data_record(1'b0);
        checks++;
        if (checksum_error !== 1'b0) begin
            errors++;
            $display("** Error: checksum_error = %h, expected %h", checksum_error, 1'b0);
        end
        send_record("9", '0, 0, 1'b0);
        wait_idle();
        verify_ram();

        // a letter past F in the count field aborts the record
        send_char("S");
        send_char("1");
        send_char("G");
        send_char(8'h0d);
        send_char(8'h0a);
        checks++;
        if (format_error !== 1'b1) begin
            errors++;
            $display("** Error: format_error = %h, expected %h", format_error, 1'b1);
        end
        run_load(FMT_RECS);
        verify_ram();
        ext_random(EXT_OPS);
        verify_ram();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tests/srec_loader_asserts.sv
module srec_loader_asserts (
    input logic                   clock,
    input logic                   rst_n,
    input loader_pkg::write_rec_t wr_rec,
    input logic                   wr_valid,
    input logic                   wr_ready,
    input loader_pkg::write_rec_t rd_rec,
    input logic                   rd_valid,
    input logic                   rd_ready,
    input loader_pkg::ahb_req_t   ram_req,
    input logic                   in_progress,
    input logic                   fifo_empty,
    input logic                   cpu_reset
);
    import loader_pkg::*;

    wr_hold: assert property (@(posedge clock) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_rec))
        else $error("wr_valid dropped or wr_rec changed before it was accepted");

    rd_hold: assert property (@(posedge clock) disable iff (!rst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_rec))
        else $error("rd_valid dropped or rd_rec changed before it was accepted");

    // only single transfers exist on this bus
    htrans_legal: assert property (@(posedge clock) disable iff (!rst_n)
        ram_req.htrans == HTRANS_IDLE || ram_req.htrans == HTRANS_NONSEQ)
        else $error("htrans is neither IDLE nor NONSEQ");

    // an idle parser holds no record for the FIFO
    cpu_released: assert property (@(posedge clock) disable iff (!rst_n)
        !in_progress && fifo_empty |-> !cpu_reset && !wr_valid)
        else $error("cpu_reset or wr_valid is high while the parser and the FIFO are idle");

endmodule

bind srec_loader_top srec_loader_asserts srec_loader_asserts_inst (
    .clock       ( HCLK        ),
    .rst_n       ( rst_n       ),
    .wr_rec      ( wr_rec      ),
    .wr_valid    ( wr_valid    ),
    .wr_ready    ( wr_ready    ),
    .rd_rec      ( rd_rec      ),
    .rd_valid    ( rd_valid    ),
    .rd_ready    ( rd_ready    ),
    .ram_req     ( ram_req     ),
    .in_progress ( in_progress ),
    .fifo_empty  ( fifo_empty  ),
    .cpu_reset   ( cpu_reset   )
);

//--- tests/clock_gen.sv
module clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- hdl/srec_loader_top.sv
module srec_loader_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 4,
    parameter int RAM_WORDS    = 256
) (
    input  logic                 HCLK,
    input  logic                 rst_n,
    input  logic                 big_endian,
    input  logic                 uart_rx,
    input  loader_pkg::ahb_req_t ext_req,
    output loader_pkg::word_t    hrdata,
    output logic                 hready,
    output logic                 hresp,
    output logic                 cpu_reset,
    output logic                 format_error,
    output logic                 checksum_error
);
    import loader_pkg::*;

    byte_t      char_data;
    logic       char_valid;
    write_rec_t wr_rec;
    logic       wr_valid;
    logic       wr_ready;
    write_rec_t rd_rec;
    logic       rd_valid;
    logic       rd_ready;
    logic       fifo_empty;
    logic       in_progress;
    logic       loading;
    ahb_req_t   loader_req;
    ahb_req_t   ram_req;

    uart_receiver #(
        .CLKS_PER_BIT ( CLKS_PER_BIT )
    ) uart_receiver_inst (
        .clock      ( HCLK       ),
        .rst_n      ( rst_n      ),
        .rx         ( uart_rx    ),
        .char_data  ( char_data  ),
        .char_valid ( char_valid )
    );

    srec_parser srec_parser_inst (
        .clock          ( HCLK           ),
        .rst_n          ( rst_n          ),
        .char_data      ( char_data      ),
        .char_valid     ( char_valid     ),
        .wr_rec         ( wr_rec         ),
        .wr_valid       ( wr_valid       ),
        .wr_ready       ( wr_ready       ),
        .in_progress    ( in_progress    ),
        .format_error   ( format_error   ),
        .checksum_error ( checksum_error )
    );

    write_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) write_fifo_inst (
        .clock     ( HCLK       ),
        .rst_n     ( rst_n      ),
        .in_rec    ( wr_rec     ),
        .in_valid  ( wr_valid   ),
        .in_ready  ( wr_ready   ),
        .out_rec   ( rd_rec     ),
        .out_valid ( rd_valid   ),
        .out_ready ( rd_ready   ),
        .empty     ( fifo_empty )
    );

    ahb_write_bridge ahb_write_bridge_inst (
        .clock      ( HCLK       ),
        .rst_n      ( rst_n      ),
        .big_endian ( big_endian ),
        .rec        ( rd_rec     ),
        .rec_valid  ( rd_valid   ),
        .rec_ready  ( rd_ready   ),
        .hready     ( hready     ),
        .req        ( loader_req )
    );

    // the loader owns the bus until the last buffered byte is written
    assign loading   = in_progress || !fifo_empty;
    assign cpu_reset = loading;
    assign ram_req   = loading ? loader_req : ext_req;

    ahb_ram #(
        .RAM_WORDS ( RAM_WORDS )
    ) ahb_ram_inst (
        .clock      ( HCLK       ),
        .rst_n      ( rst_n      ),
        .big_endian ( big_endian ),
        .req        ( ram_req    ),
        .hrdata     ( hrdata     ),
        .hready     ( hready     ),
        .hresp      ( hresp      )
    );

endmodule

//--- hdl/ahb_ram.sv
module ahb_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 big_endian,
    input  loader_pkg::ahb_req_t req,
    output loader_pkg::word_t    hrdata,
    output logic                 hready,
    output logic                 hresp
);
    import loader_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    word_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] idx_q;
    logic [3:0]       strb_q;
    logic [3:0]       strb_le;
    logic [3:0]       strb;
    logic             sel;

    assign hready = 1'b1;
    assign hresp  = 1'b0;
    assign sel    = (req.htrans == HTRANS_NONSEQ);

    always_comb begin
        case (req.hsize)
            HSIZE_BYTE: strb_le = 4'b0001 << req.haddr[1:0];
            HSIZE_HALF: strb_le = req.haddr[1] ? 4'b1100 : 4'b0011;
            HSIZE_WORD: strb_le = 4'b1111;
            default:    strb_le = 4'b0000;
        endcase
    end

    // mirror the lanes for big endian
    assign strb = big_endian ? {strb_le[0], strb_le[1], strb_le[2], strb_le[3]} : strb_le;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            strb_q <= '0;
        end else begin
            strb_q <= (sel && req.hwrite) ? strb : 4'b0000;
        end
    end

    // the word index wraps at the RAM size
    always_ff @(posedge clock) begin
        idx_q <= req.haddr[IDX_W+1:2];
        for (int i = 0; i < 4; i++) begin
            if (strb_q[i]) begin
                mem[idx_q][8*i +: 8] <= req.hwdata[8*i +: 8];
            end
        end
    end

    assign hrdata = mem[idx_q];

endmodule

//--- hdl/ahb_write_bridge.sv
module ahb_write_bridge (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   big_endian,
    input  loader_pkg::write_rec_t rec,
    input  logic                   rec_valid,
    output logic                   rec_ready,
    input  logic                   hready,
    output loader_pkg::ahb_req_t   req
);
    import loader_pkg::*;

    logic       pop;
    logic [1:0] lane;
    word_t      hwdata_q;

    // the address phase completes whenever the bus is ready
    assign rec_ready = hready;
    assign pop       = rec_valid && hready;

    // big endian puts the lowest address in the top byte lane
    assign lane = big_endian ? ~rec.addr[1:0] : rec.addr[1:0];

    always_comb begin
        req.haddr  = rec.addr;
        req.htrans = rec_valid ? HTRANS_NONSEQ : HTRANS_IDLE;
        req.hsize  = HSIZE_BYTE;
        req.hwrite = 1'b1;
        req.hwdata = hwdata_q;
    end

    // data phase of the popped record, held while the slave stalls
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hwdata_q <= '0;
        end else if (pop) begin
            hwdata_q <= word_t'(rec.data) << {lane, 3'b000};
        end
    end

endmodule

//--- hdl/write_fifo.sv
module write_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  loader_pkg::write_rec_t in_rec,
    input  logic                   in_valid,
    output logic                   in_ready,
    output loader_pkg::write_rec_t out_rec,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic                   empty
);
    import loader_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    write_rec_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign out_valid = !empty;
    assign out_rec   = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_rec;
        end
    end

endmodule

//--- hdl/srec_parser.sv
module srec_parser (
    input  logic                   clock,
    input  logic                   rst_n,
    input  loader_pkg::byte_t      char_data,
    input  logic                   char_valid,
    output loader_pkg::write_rec_t wr_rec,
    output logic                   wr_valid,
    input  logic                   wr_ready,
    output logic                   in_progress,
    output logic                   format_error,
    output logic                   checksum_error
);
    import loader_pkg::*;

    typedef enum logic [2:0] {
        ST_WAIT_S,
        ST_TYPE,
        ST_COUNT,
        ST_ADDR,
        ST_DATA,
        ST_CSUM
    } srec_state_t;

    srec_state_t state;
    logic [3:0]  rec_type;
    logic [3:0]  hex_hi;
    logic        have_hi;
    logic [2:0]  addr_left;
    byte_t       bytes_left;
    byte_t       sum;
    addr_t       addr;

    logic        hex_ok;
    logic [3:0]  nib;
    byte_t       cur_byte;
    logic        is_data_rec;
    logic        is_term_rec;

    // msb of the result flags a valid hex digit
    function automatic logic [4:0] hex_value(input byte_t c);
        logic [4:0] v;
        v = 5'b0;
        if (c >= "0" && c <= "9") begin
            v = {1'b1, c[3:0]};
        end else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) begin
            v = {1'b1, c[3:0] + 4'd9};
        end
        return v;
    endfunction

    assign {hex_ok, nib} = hex_value(char_data);
    assign cur_byte      = {hex_hi, nib};
    assign is_data_rec   = rec_type inside {4'd1, 4'd2, 4'd3};
    assign is_term_rec   = rec_type inside {4'd7, 4'd8, 4'd9};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state          <= ST_WAIT_S;
            have_hi        <= 1'b0;
            addr_left      <= '0;
            bytes_left     <= '0;
            wr_valid       <= 1'b0;
            in_progress    <= 1'b0;
            format_error   <= 1'b0;
            checksum_error <= 1'b0;
        end else begin
            if (wr_valid && wr_ready) begin
                wr_valid <= 1'b0;
            end
            if (char_valid) begin
                case (state)
                    ST_WAIT_S: begin
                        if (char_data == "S") begin
                            state          <= ST_TYPE;
                            in_progress    <= 1'b1;
                            format_error   <= 1'b0;
                            checksum_error <= 1'b0;
                        end else if (char_data != 8'h0d && char_data != 8'h0a) begin
                            format_error <= 1'b1;
                        end
                    end
                    ST_TYPE: begin
                        rec_type <= char_data[3:0];
                        have_hi  <= 1'b0;
                        state    <= ST_COUNT;
                        // address length in bytes follows from the type digit
                        case (char_data)
                            "0", "1", "9": addr_left <= 3'd2;
                            "2", "8":      addr_left <= 3'd3;
                            "3", "7":      addr_left <= 3'd4;
                            default: begin
                                format_error <= 1'b1;
                                state        <= ST_WAIT_S;
                            end
                        endcase
                    end
                    default: begin
                        if (!hex_ok) begin
                            format_error <= 1'b1;
                            state        <= ST_WAIT_S;
                        end else if (!have_hi) begin
                            hex_hi  <= nib;
                            have_hi <= 1'b1;
                        end else begin
                            have_hi <= 1'b0;
                            case (state)
                                ST_COUNT: begin
                                    bytes_left <= cur_byte;
                                    sum        <= cur_byte;
                                    addr       <= '0;
                                    state      <= ST_ADDR;
                                    // the count must cover the address and checksum
                                    if (cur_byte <= byte_t'(addr_left)) begin
                                        format_error <= 1'b1;
                                        state        <= ST_WAIT_S;
                                    end
                                end
                                ST_ADDR: begin
                                    addr       <= {addr[23:0], cur_byte};
                                    sum        <= sum + cur_byte;
                                    bytes_left <= bytes_left - 1'b1;
                                    addr_left  <= addr_left - 1'b1;
                                    if (addr_left == 3'd1) begin
                                        state <= (bytes_left == 8'd2) ? ST_CSUM : ST_DATA;
                                    end
                                end
                                ST_DATA: begin
                                    sum        <= sum + cur_byte;
                                    bytes_left <= bytes_left - 1'b1;
                                    if (is_data_rec) begin
                                        wr_rec   <= '{addr: addr, data: cur_byte};
                                        wr_valid <= 1'b1;
                                        addr     <= addr + 1'b1;
                                    end
                                    if (bytes_left == 8'd2) begin
                                        state <= ST_CSUM;
                                    end
                                end
                                ST_CSUM: begin
                                    if (cur_byte != ~sum) begin
                                        checksum_error <= 1'b1;
                                    end
                                    if (is_term_rec) begin
                                        in_progress <= 1'b0;
                                    end
                                    state <= ST_WAIT_S;
                                end
                                default: ;
                            endcase
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/uart_receiver.sv
module uart_receiver #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              rx,
    output loader_pkg::byte_t char_data,
    output logic              char_valid
);
    import loader_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    localparam int CNT_W    = $clog2(CLKS_PER_BIT + 1);
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             bit_tick;

    assign bit_tick = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rx_sync    <= 2'b11;
            state      <= RX_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            char_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], rx};
            char_valid <= 1'b0;
            cnt        <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // a start bit that is gone at mid-bit was only a glitch
                    if (cnt == CNT_W'(HALF_BIT - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_tick) begin
                        char_valid <= rx_sync[1];
                        state      <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clock) begin
        if (state == RX_DATA && bit_tick) begin
            char_data <= {rx_sync[1], char_data[7:1]};
        end
    end

endmodule

//--- hdl/loader_pkg.sv
package loader_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  htrans_t;
    typedef logic [2:0]  hsize_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    localparam hsize_t HSIZE_BYTE = 3'b000;
    localparam hsize_t HSIZE_HALF = 3'b001;
    localparam hsize_t HSIZE_WORD = 3'b010;

    // one byte that a data record asks to be written
    typedef struct packed {
        addr_t addr;
        byte_t data;
    } write_rec_t;

    // address phase and data phase of one master, hwdata trails by a cycle
    typedef struct packed {
        addr_t   haddr;
        htrans_t htrans;
        hsize_t  hsize;
        logic    hwrite;
        word_t   hwdata;
    } ahb_req_t;

endpackage
